// File: vga_display.f
+incdir+bench
rtl/vga_pkg.sv
rtl/vga_timing.sv
rtl/upscale_addr.sv
rtl/frame_buffer.sv
rtl/display_regs.sv
rtl/pixel_delay.sv
rtl/pixel_shader.sv
rtl/vga_display.sv
bench/vga_display_tb.sv

// File: bench/vga_ref_model.svh
/* testbench model, included inside vga_display_tb after the mode and buffer localparams
   mirrors buffer words and control bits as they are written */
`ifndef VGA_REF_MODEL_SVH
`define VGA_REF_MODEL_SVH

// ########################################
// mirrored state
// ########################################

// buffer contents as written through the write port
vga_pkg::pixel_t model_mem [BUF_DEPTH];
// control bits, both clear after reset
logic model_source_sel = 1'b0;
logic model_mute       = 1'b0;

// record one buffer write
function automatic void model_write_pixel(input int addr, input vga_pkg::pixel_t data);
    model_mem[addr] = data;
endfunction

// record one configuration write
function automatic void model_write_reg(input logic addr, input logic data);
    if (addr == vga_pkg::REG_SOURCE) begin
        model_source_sel = data;
    end else begin
        model_mute = data;
    end
endfunction

// ########################################
// expected picture
// ########################################

// buffer word under a screen position, whole-factor upscale
function automatic int model_addr(input int sx, input int sy);
    return (sy / V_SCALE) * BUF_W + (sx / H_SCALE);
endfunction

// blue full, green from low y bits, red from low x bits
function automatic vga_pkg::pixel_t model_gradient(input int sx, input int sy);
    logic [3:0] gx;
    logic [3:0] gy;
    gx = sx[3:0];
    gy = sy[3:0];
    return {4'hf, gy, gx};
endfunction

// colour expected at the ports for screen position (sx, sy)
function automatic vga_pkg::pixel_t model_pixel(input int sx, input int sy);
    // blanking or mute gives black
    if (sx >= H_ACTIVE || sy >= V_ACTIVE || model_mute) begin
        return '0;
    end
    if (model_source_sel) begin
        return model_gradient(sx, sy);
    end
    return model_mem[model_addr(sx, sy)];
endfunction

`endif

// File: bench/vga_display_tb.sv
/* small simulation mode with a 16x12 buffer, scale 2 both ways
   screen position is recovered from the port syncs, so pixel checks begin after the first vsync */
`timescale 1ns/1ns

module vga_display_tb;

    localparam vga_pkg::video_mode_t VMODE = vga_pkg::VMODE_SIM_32X24;
    localparam int BUF_W     = 16;
    localparam int BUF_H     = 12;
    localparam int BUF_DEPTH = BUF_W * BUF_H;
    localparam int ADDR_W    = $clog2(BUF_DEPTH);
    localparam int H_ACTIVE  = VMODE.h_active;
    localparam int V_ACTIVE  = VMODE.v_active;
    localparam int H_SCALE   = H_ACTIVE / BUF_W;
    localparam int V_SCALE   = V_ACTIVE / BUF_H;
    // line and frame totals straight from the porch counts
    localparam int H_TOTAL = H_ACTIVE + VMODE.h_front_porch + VMODE.h_sync + VMODE.h_back_porch;
    localparam int V_TOTAL = V_ACTIVE + VMODE.v_front_porch + VMODE.v_sync + VMODE.v_back_porch;
    // first position after each sync interval
    localparam int H_SYNC_END = H_ACTIVE + VMODE.h_front_porch + VMODE.h_sync;
    localparam int V_SYNC_END = V_ACTIVE + VMODE.v_front_porch + VMODE.v_sync;
    localparam logic HS_ACTIVE = VMODE.h_sync_pol;
    localparam logic VS_ACTIVE = VMODE.v_sync_pol;
    localparam logic HS_IDLE   = ~VMODE.h_sync_pol;
    localparam logic VS_IDLE   = ~VMODE.v_sync_pol;
    localparam int RESET_CYCLES   = 10;
    localparam int WAIT_LIMIT     = 2 * H_TOTAL * V_TOTAL;
    localparam int REWRITE_WORDS  = 12;
    // image x2, gradient, mute, image x2 after rewrites
    localparam int CHECKED_FRAMES = 6;

    logic                clk_pixel;
    logic                rstn_pixel;
    logic                cfg_wr;
    logic                cfg_addr;
    logic                cfg_data;
    logic                fb_wr;
    logic [ADDR_W-1:0]   fb_waddr;
    vga_pkg::pixel_t     fb_wdata;
    logic                vga_hsync;
    logic                vga_vsync;
    logic [3:0]          vga_red;
    logic [3:0]          vga_green;
    logic [3:0]          vga_blue;

    int          error_count  = 0;
    logic [31:0] lcg_state    = 32'h2974;
    logic        timed_out    = 1'b0;
    logic        check_active = 1'b0;

    // raster tracker state, all in port samples
    int   sample_count = 0;
    int   hs_start     = 0;
    int   vs_start     = 0;
    logic hs_seen      = 1'b0;
    logic vs_seen      = 1'b0;
    logic prev_hs      = 1'b0;
    logic prev_vs      = 1'b0;
    logic h_locked     = 1'b0;
    logic v_locked     = 1'b0;
    int   cur_x        = 0;
    int   cur_y        = 0;
    int   lines_checked  = 0;
    int   frames_checked = 0;
    int   pixels_checked = 0;

    `include "vga_ref_model.svh"

    vga_display #(
        .VIDEO_MODE(VMODE), .BUFFER_WIDTH(BUF_W), .BUFFER_HEIGHT(BUF_H)
    ) vga_display_inst (
        .clk_pixel(clk_pixel), .rstn_pixel(rstn_pixel),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .fb_wr(fb_wr), .fb_waddr(fb_waddr), .fb_wdata(fb_wdata),
        .vga_hsync(vga_hsync), .vga_vsync(vga_vsync),
        .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue)
    );

    // 10 ns pixel clock
    initial begin
        clk_pixel = 1'b0;
        forever #5 clk_pixel = ~clk_pixel;
    end

    // ########################################
    // helpers
    // ########################################

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("[FAIL] %s expected 0x%0h actual 0x%0h at %0t ns",
                     name, expected, actual, $time);
        end
    endtask

    // syncs inactive and colour black
    task automatic check_idle_outputs();
        check_value("vga_hsync", HS_IDLE, vga_hsync);
        check_value("vga_vsync", VS_IDLE, vga_vsync);
        check_value("vga_red", 0, vga_red);
        check_value("vga_green", 0, vga_green);
        check_value("vga_blue", 0, vga_blue);
    endtask

    // returns on the sample where vsync turns active
    task automatic wait_vsync_start();
        int   waited;
        logic was_on;
        logic is_on;
        logic found;
        if (!timed_out) begin
            waited = 0;
            found  = 1'b0;
            @(negedge clk_pixel);
            was_on = (vga_vsync === VS_ACTIVE);
            while (!found && waited < WAIT_LIMIT) begin
                @(negedge clk_pixel);
                is_on  = (vga_vsync === VS_ACTIVE);
                found  = is_on && !was_on;
                was_on = is_on;
                waited++;
            end
            if (!found) begin
                timed_out = 1'b1;
                error_count++;
                $display("timeout: no vsync pulse began within %0d cycles", WAIT_LIMIT);
            end
        end
    endtask

    // single-cycle configuration strobe
    task automatic write_cfg(input logic addr, input logic data);
        @(posedge clk_pixel);
        cfg_wr   <= 1'b1;
        cfg_addr <= addr;
        cfg_data <= data;
        model_write_reg(addr, data);
        @(posedge clk_pixel);
        cfg_wr <= 1'b0;
    endtask

    // single-cycle buffer write strobe
    task automatic write_pixel(input int addr, input vga_pkg::pixel_t data);
        @(posedge clk_pixel);
        fb_wr    <= 1'b1;
        fb_waddr <= ADDR_W'(addr);
        fb_wdata <= data;
        model_write_pixel(addr, data);
        @(posedge clk_pixel);
        fb_wr <= 1'b0;
    endtask

    task automatic fill_buffer();
        logic [31:0] rnd;
        for (int a = 0; a < BUF_DEPTH; a++) begin
            rnd = next_random();
            write_pixel(a, rnd[27:16]);
        end
    endtask

    // random words at random addresses
    task automatic rewrite_random_words(input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd = next_random();
            write_pixel(int'(rnd[31:16] % BUF_DEPTH), rnd[27:16]);
        end
    endtask

    // ########################################
    // port monitor
    // ########################################

    // steps the tracked position and measures sync pulses
    task automatic track_position();
        logic hs_on;
        logic vs_on;
        hs_on = (vga_hsync === HS_ACTIVE);
        vs_on = (vga_vsync === VS_ACTIVE);
        sample_count++;
        if (h_locked) begin
            if (cur_x == H_TOTAL - 1) begin
                cur_x = 0;
                if (v_locked) begin
                    cur_y = (cur_y == V_TOTAL - 1) ? 0 : cur_y + 1;
                end
            end else begin
                cur_x++;
            end
        end
        // leading edges give the periods
        if (hs_on && !prev_hs) begin
            if (hs_seen) begin
                check_value("vga_hsync period", H_TOTAL, sample_count - hs_start);
                lines_checked++;
            end
            hs_start = sample_count;
            hs_seen  = 1'b1;
        end
        if (vs_on && !prev_vs) begin
            if (vs_seen) begin
                check_value("vga_vsync period", H_TOTAL * V_TOTAL, sample_count - vs_start);
                frames_checked++;
            end
            vs_start = sample_count;
            vs_seen  = 1'b1;
        end
        // trailing edges give the widths and the position
        if (!hs_on && prev_hs) begin
            check_value("vga_hsync width", VMODE.h_sync, sample_count - hs_start);
            cur_x    = H_SYNC_END;
            h_locked = 1'b1;
        end
        if (!vs_on && prev_vs) begin
            check_value("vga_vsync width", VMODE.v_sync * H_TOTAL, sample_count - vs_start);
            cur_y    = V_SYNC_END;
            v_locked = 1'b1;
        end
        prev_hs = hs_on;
        prev_vs = vs_on;
    endtask

    // blanking always black, active pixels once checking is on
    task automatic check_pixel();
        vga_pkg::pixel_t expected;
        logic            active;
        if (h_locked && v_locked) begin
            active = (cur_x < H_ACTIVE) && (cur_y < V_ACTIVE);
            if (!active || check_active) begin
                expected = model_pixel(cur_x, cur_y);
                check_value("vga_red", expected[3:0], vga_red);
                check_value("vga_green", expected[7:4], vga_green);
                check_value("vga_blue", expected[11:8], vga_blue);
                if (active) begin
                    pixels_checked++;
                end
            end
        end
    endtask

    // outputs settle after the rising edge, sample on the falling one
    always @(negedge clk_pixel) begin
        if (rstn_pixel) begin
            track_position();
            check_pixel();
        end
    end

    // ########################################
    // stimulus
    // ########################################

    initial begin
        rstn_pixel = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = 1'b0;
        cfg_data   = 1'b0;
        fb_wr      = 1'b0;
        fb_waddr   = '0;
        fb_wdata   = '0;

        // idle outputs in reset and until pixel (0, 0) arrives 3 cycles later
        repeat (RESET_CYCLES - 1) @(posedge clk_pixel);
        @(negedge clk_pixel);
        check_idle_outputs();
        @(posedge clk_pixel);
        rstn_pixel <= 1'b1;
        repeat (3) begin
            @(negedge clk_pixel);
            check_idle_outputs();
        end

        // first frame shows unwritten words, not checked
        fill_buffer();

        // image, unmuted
        wait_vsync_start();
        write_cfg(vga_pkg::REG_SOURCE, 1'b0);
        write_cfg(vga_pkg::REG_MUTE, 1'b0);
        check_active = 1'b1;
        repeat (2) wait_vsync_start();

        // gradient
        write_cfg(vga_pkg::REG_SOURCE, 1'b1);
        wait_vsync_start();

        // muted, syncs keep running
        write_cfg(vga_pkg::REG_MUTE, 1'b1);
        wait_vsync_start();

        // image again, new words land in vertical blanking
        write_cfg(vga_pkg::REG_MUTE, 1'b0);
        write_cfg(vga_pkg::REG_SOURCE, 1'b0);
        repeat (2) begin
            rewrite_random_words(REWRITE_WORDS);
            wait_vsync_start();
        end

        // let the monitor finish the last sample
        @(posedge clk_pixel);
        assert (pixels_checked == CHECKED_FRAMES * H_ACTIVE * V_ACTIVE &&
                frames_checked >= CHECKED_FRAMES) else begin
            error_count++;
            $display("fewer pixels or frames were checked than expected: %0d pixels, %0d frames",
                     pixels_checked, frames_checked);
        end
        $display("checked %0d pixels, %0d lines, %0d frames, errors %0d",
                 pixels_checked, lines_checked, frames_checked, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/vga_display.sv
/* buffer size must divide the active area evenly; no clock generation inside
   output lags the raster counters by 3 cycles */
`timescale 1ns/1ns

module vga_display #(
    parameter vga_pkg::video_mode_t VIDEO_MODE = vga_pkg::VMODE_640X480P60,
    parameter int BUFFER_WIDTH  = 320,
    parameter int BUFFER_HEIGHT = 240
) (
    input  logic clk_pixel,
    input  logic rstn_pixel,
    // configuration
    input  logic cfg_wr,
    input  logic cfg_addr,
    input  logic cfg_data,
    // frame-buffer writes
    input  logic fb_wr,
    input  logic [$clog2(BUFFER_WIDTH * BUFFER_HEIGHT)-1:0] fb_waddr,
    input  vga_pkg::pixel_t fb_wdata,
    // video out
    output logic vga_hsync,
    output logic vga_vsync,
    output logic [vga_pkg::COLOR_W-1:0] vga_red,
    output logic [vga_pkg::COLOR_W-1:0] vga_green,
    output logic [vga_pkg::COLOR_W-1:0] vga_blue
);

    localparam int DEPTH = BUFFER_WIDTH * BUFFER_HEIGHT;
    localparam int X_W   = $clog2(vga_pkg::h_total(VIDEO_MODE));
    localparam int Y_W   = $clog2(vga_pkg::v_total(VIDEO_MODE));

    // delayed syncs must come out of reset inactive
    localparam vga_pkg::sync_bundle_t SYNC_IDLE = '{
        hsync: ~VIDEO_MODE.h_sync_pol, vsync: ~VIDEO_MODE.v_sync_pol, de: 1'b0
    };

    logic [X_W-1:0]           x;
    logic [Y_W-1:0]           y;
    logic                     hsync_raw, vsync_raw, de_raw;
    logic [$clog2(DEPTH)-1:0] rd_addr;
    vga_pkg::pixel_t          rd_data;
    vga_pkg::sync_bundle_t    sync_now, sync_dly;
    vga_pkg::pattern_coord_t  coord_now, coord_dly;
    logic                     source_sel, mute;

    // ########################################
    // raster and address path
    // ########################################

    vga_timing #(.VIDEO_MODE(VIDEO_MODE)) vga_timing_inst (
        .clk_pixel(clk_pixel), .rstn_pixel(rstn_pixel), .x(x), .y(y),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .de_raw(de_raw)
    );

    upscale_addr #(
        .VIDEO_MODE(VIDEO_MODE), .BUFFER_WIDTH(BUFFER_WIDTH), .BUFFER_HEIGHT(BUFFER_HEIGHT)
    ) upscale_addr_inst (
        .clk_pixel(clk_pixel), .rstn_pixel(rstn_pixel), .x(x), .y(y), .rd_addr(rd_addr)
    );

    frame_buffer #(.DEPTH(DEPTH)) frame_buffer_inst (
        .clk_pixel(clk_pixel), .fb_wr(fb_wr), .fb_waddr(fb_waddr), .fb_wdata(fb_wdata),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    // ########################################
    // alignment with read data
    // ########################################

    assign sync_now  = '{hsync: hsync_raw, vsync: vsync_raw, de: de_raw};
    assign coord_now = '{x: x[3:0], y: y[3:0]};

    pixel_delay #(
        .payload_t(vga_pkg::sync_bundle_t), .DEPTH(vga_pkg::PIPE_DEPTH),
        .RESET_VALUE(SYNC_IDLE)
    ) sync_delay_inst (
        .clk_pixel(clk_pixel), .rstn_pixel(rstn_pixel), .din(sync_now), .dout(sync_dly)
    );

    pixel_delay #(
        .payload_t(vga_pkg::pattern_coord_t), .DEPTH(vga_pkg::PIPE_DEPTH),
        .RESET_VALUE('0)
    ) coord_delay_inst (
        .clk_pixel(clk_pixel), .rstn_pixel(rstn_pixel), .din(coord_now), .dout(coord_dly)
    );

    // ########################################
    // control and output stage
    // ########################################

    display_regs display_regs_inst (
        .clk_pixel(clk_pixel), .rstn_pixel(rstn_pixel), .cfg_wr(cfg_wr),
        .cfg_addr(cfg_addr), .cfg_data(cfg_data), .source_sel(source_sel), .mute(mute)
    );

    pixel_shader #(.VIDEO_MODE(VIDEO_MODE)) pixel_shader_inst (
        .clk_pixel(clk_pixel), .rstn_pixel(rstn_pixel), .sync_in(sync_dly),
        .coord_in(coord_dly), .rd_data(rd_data), .source_sel(source_sel), .mute(mute),
        .vga_hsync(vga_hsync), .vga_vsync(vga_vsync),
        .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue)
    );

endmodule

// File: rtl/pixel_shader.sv
/* inputs must already be aligned with the RAM read data
   outputs are registered, one cycle after the inputs */
`timescale 1ns/1ns

module pixel_shader #(
    parameter vga_pkg::video_mode_t VIDEO_MODE = vga_pkg::VMODE_640X480P60
) (
    input  logic                         clk_pixel,
    input  logic                         rstn_pixel,
    input  vga_pkg::sync_bundle_t        sync_in,
    input  vga_pkg::pattern_coord_t      coord_in,
    input  vga_pkg::pixel_t              rd_data,
    input  logic                         source_sel,
    input  logic                         mute,
    output logic                         vga_hsync,
    output logic                         vga_vsync,
    output logic [vga_pkg::COLOR_W-1:0]  vga_red,
    output logic [vga_pkg::COLOR_W-1:0]  vga_green,
    output logic [vga_pkg::COLOR_W-1:0]  vga_blue
);

    localparam int CW = vga_pkg::COLOR_W;

    vga_pkg::pixel_t gradient;
    vga_pkg::pixel_t chosen;
    vga_pkg::pixel_t shown;

    // ########################################
    // colour selection
    // ########################################

    always_comb begin
        // blue full, green from y, red from x
        gradient = {{CW{1'b1}}, coord_in.y, coord_in.x};
        chosen   = source_sel ? gradient : rd_data;
        // black in blanking or while muted
        shown    = (sync_in.de && !mute) ? chosen : '0;
    end

    // ########################################
    // output registers
    // ########################################

    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            // inactive sync level is the inverse of the polarity
            vga_hsync <= ~VIDEO_MODE.h_sync_pol;
            vga_vsync <= ~VIDEO_MODE.v_sync_pol;
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
        end else begin
            vga_hsync <= sync_in.hsync;
            vga_vsync <= sync_in.vsync;
            vga_red   <= shown[CW-1:0];
            vga_green <= shown[2*CW-1:CW];
            vga_blue  <= shown[3*CW-1:2*CW];
        end
    end

endmodule

// File: rtl/pixel_delay.sv
/* DEPTH must be at least 1; every stage loads RESET_VALUE on reset */
`timescale 1ns/1ns

module pixel_delay #(
    parameter type      payload_t   = logic,
    parameter int       DEPTH       = 2,
    parameter payload_t RESET_VALUE = '0
) (
    input  logic     clk_pixel,
    input  logic     rstn_pixel,
    input  payload_t din,
    output payload_t dout
);

    // stage 0 takes the input, last stage drives the output
    payload_t stage [DEPTH];

    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= RESET_VALUE;
            end
        end else begin
            stage[0] <= din;
            // shift the rest down the chain
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

// File: rtl/display_regs.sv
/* write-only control bits, no readback path
   each write strobe updates exactly one bit */
`timescale 1ns/1ns

module display_regs (
    input  logic clk_pixel,
    input  logic rstn_pixel,
    // configuration write strobe
    input  logic cfg_wr,
    input  logic cfg_addr,
    input  logic cfg_data,
    // control levels to the shader
    output logic source_sel,
    output logic mute
);

    // ########################################
    // register decode
    // ########################################

    // source_sel 0 shows the buffer and 1 shows the gradient
    // mute blacks out all colour while the syncs keep running
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            source_sel <= 1'b0;
            mute       <= 1'b0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                vga_pkg::REG_SOURCE: begin
                    source_sel <= cfg_data;
                end
                vga_pkg::REG_MUTE: begin
                    mute <= cfg_data;
                end
            endcase
        end
    end

endmodule

// File: rtl/frame_buffer.sv
/* simple dual-port RAM, contents undefined until written
   same-address read and write in one cycle returns the old word */
`timescale 1ns/1ns

module frame_buffer #(
    parameter int DEPTH = 320 * 240
) (
    input  logic                     clk_pixel,
    // write side, one word per strobe
    input  logic                     fb_wr,
    input  logic [$clog2(DEPTH)-1:0] fb_waddr,
    input  vga_pkg::pixel_t          fb_wdata,
    // video read side
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output vga_pkg::pixel_t          rd_data
);

    // ########################################
    // storage
    // ########################################

    vga_pkg::pixel_t mem [DEPTH];

    // write port
    always_ff @(posedge clk_pixel) begin
        if (fb_wr) begin
            mem[fb_waddr] <= fb_wdata;
        end
    end

    // read port, data one cycle after address
    always_ff @(posedge clk_pixel) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rtl/upscale_addr.sv
/* active size must be a whole multiple of the buffer size in each direction
   address is forced to 0 outside the active area */
`timescale 1ns/1ns

module upscale_addr #(
    parameter vga_pkg::video_mode_t VIDEO_MODE = vga_pkg::VMODE_640X480P60,
    parameter int BUFFER_WIDTH  = 320,
    parameter int BUFFER_HEIGHT = 240
) (
    input  logic clk_pixel,
    input  logic rstn_pixel,
    input  logic [$clog2(vga_pkg::h_total(VIDEO_MODE))-1:0] x,
    input  logic [$clog2(vga_pkg::v_total(VIDEO_MODE))-1:0] y,
    output logic [$clog2(BUFFER_WIDTH * BUFFER_HEIGHT)-1:0] rd_addr
);

    localparam int X_W    = $clog2(vga_pkg::h_total(VIDEO_MODE));
    localparam int Y_W    = $clog2(vga_pkg::v_total(VIDEO_MODE));
    localparam int ADDR_W = $clog2(BUFFER_WIDTH * BUFFER_HEIGHT);
    // integer scale factors
    localparam int HS   = VIDEO_MODE.h_active / BUFFER_WIDTH;
    localparam int VS   = VIDEO_MODE.v_active / BUFFER_HEIGHT;
    localparam int HP_W = $clog2(HS + 1);
    localparam int VP_W = $clog2(VS + 1);

    // state as seen at the previous pixel / previous line start
    logic [ADDR_W-1:0] col_q, row_base_q;
    logic [HP_W-1:0]   hphase_q;
    logic [VP_W-1:0]   vphase_q;
    // values belonging to the current position
    logic [ADDR_W-1:0] col_cur, row_base_cur;
    logic [HP_W-1:0]   hphase_cur;
    logic [VP_W-1:0]   vphase_cur;
    logic              line_start;
    logic              active;

    always_comb begin
        line_start = (x == '0);
        active     = (x < X_W'(VIDEO_MODE.h_active)) && (y < Y_W'(VIDEO_MODE.v_active));

        // column steps once every HS pixels, restart at x = 0
        if (line_start) begin
            col_cur    = '0;
            hphase_cur = '0;
        end else if (hphase_q == HP_W'(HS - 1)) begin
            col_cur    = col_q + 1'b1;
            hphase_cur = '0;
        end else begin
            col_cur    = col_q;
            hphase_cur = hphase_q + 1'b1;
        end

        // row base moves by one buffer line every VS screen lines
        if (!line_start) begin
            row_base_cur = row_base_q;
            vphase_cur   = vphase_q;
        end else if (y == '0) begin
            row_base_cur = '0;
            vphase_cur   = '0;
        end else if (vphase_q == VP_W'(VS - 1)) begin
            row_base_cur = row_base_q + ADDR_W'(BUFFER_WIDTH);
            vphase_cur   = '0;
        end else begin
            row_base_cur = row_base_q;
            vphase_cur   = vphase_q + 1'b1;
        end
    end

    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            col_q      <= '0;
            hphase_q   <= '0;
            row_base_q <= '0;
            vphase_q   <= '0;
            rd_addr    <= '0;
        end else begin
            col_q      <= col_cur;
            hphase_q   <= hphase_cur;
            row_base_q <= row_base_cur;
            vphase_q   <= vphase_cur;
            // blanking reads word 0, the shader blacks it out anyway
            rd_addr    <= active ? (row_base_cur + col_cur) : '0;
        end
    end

endmodule

// File: rtl/vga_timing.sv
/* free-running raster counters; sync and enable are combinational from the counters
   and should be registered downstream before reaching pins */
`timescale 1ns/1ns

module vga_timing #(
    parameter vga_pkg::video_mode_t VIDEO_MODE = vga_pkg::VMODE_640X480P60
) (
    input  logic clk_pixel,
    input  logic rstn_pixel,
    output logic [$clog2(vga_pkg::h_total(VIDEO_MODE))-1:0] x,
    output logic [$clog2(vga_pkg::v_total(VIDEO_MODE))-1:0] y,
    output logic hsync_raw,
    output logic vsync_raw,
    output logic de_raw
);

    localparam int H_TOTAL = vga_pkg::h_total(VIDEO_MODE);
    localparam int V_TOTAL = vga_pkg::v_total(VIDEO_MODE);
    localparam int X_W     = $clog2(H_TOTAL);
    localparam int Y_W     = $clog2(V_TOTAL);

    // sync interval sits after active area and front porch
    localparam int H_SYNC_START = VIDEO_MODE.h_active + VIDEO_MODE.h_front_porch;
    localparam int H_SYNC_END   = H_SYNC_START + VIDEO_MODE.h_sync;
    localparam int V_SYNC_START = VIDEO_MODE.v_active + VIDEO_MODE.v_front_porch;
    localparam int V_SYNC_END   = V_SYNC_START + VIDEO_MODE.v_sync;

    logic h_in_sync;
    logic v_in_sync;

    // ########################################
    // position counters
    // ########################################

    // x walks the whole line, y steps when x wraps
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            x <= '0;
            y <= '0;
        end else if (x == X_W'(H_TOTAL - 1)) begin
            x <= '0;
            // last line of the frame wraps to the top
            if (y == Y_W'(V_TOTAL - 1)) begin
                y <= '0;
            end else begin
                y <= y + 1'b1;
            end
        end else begin
            x <= x + 1'b1;
        end
    end

    // ########################################
    // sync and enable levels
    // ########################################

    always_comb begin
        h_in_sync = (x >= X_W'(H_SYNC_START)) && (x < X_W'(H_SYNC_END));
        v_in_sync = (y >= Y_W'(V_SYNC_START)) && (y < Y_W'(V_SYNC_END));

        // flip for active-low modes
        hsync_raw = VIDEO_MODE.h_sync_pol ? h_in_sync : ~h_in_sync;
        vsync_raw = VIDEO_MODE.v_sync_pol ? v_in_sync : ~v_in_sync;

        // visible area only
        de_raw = (x < X_W'(VIDEO_MODE.h_active)) && (y < Y_W'(VIDEO_MODE.v_active));
    end

endmodule

// File: rtl/vga_pkg.sv
/* shared video types and constants; mode widths beyond 16 bits per field are not expected
   pixel layout is red in the low nibble, blue in the high nibble */
package vga_pkg;

    // ########################################
    // video mode description
    // ########################################

    // porch and sync lengths in pixels or lines, polarity 1 = active high
    typedef struct packed {
        int h_active;
        int h_front_porch;
        int h_sync;
        int h_back_porch;
        int v_active;
        int v_front_porch;
        int v_sync;
        int v_back_porch;
        bit h_sync_pol;
        bit v_sync_pol;
    } video_mode_t;

    // standard 640x480 at 60 Hz, both syncs negative
    localparam video_mode_t VMODE_640X480P60 = '{
        h_active: 640, h_front_porch: 16, h_sync: 96, h_back_porch: 48,
        v_active: 480, v_front_porch: 10, v_sync: 2, v_back_porch: 33,
        h_sync_pol: 1'b0, v_sync_pol: 1'b0
    };

    // tiny mode so a frame fits in a short simulation
    localparam video_mode_t VMODE_SIM_32X24 = '{
        h_active: 32, h_front_porch: 2, h_sync: 4, h_back_porch: 2,
        v_active: 24, v_front_porch: 1, v_sync: 2, v_back_porch: 1,
        h_sync_pol: 1'b0, v_sync_pol: 1'b1
    };

    // full line length including blanking
    function automatic int h_total(video_mode_t m);
        return m.h_active + m.h_front_porch + m.h_sync + m.h_back_porch;
    endfunction

    // full frame height including blanking
    function automatic int v_total(video_mode_t m);
        return m.v_active + m.v_front_porch + m.v_sync + m.v_back_porch;
    endfunction

    // ########################################
    // pixel and pipeline payloads
    // ########################################

    localparam int COLOR_W = 4;
    localparam int PIXEL_W = 3 * COLOR_W;

    // {blue, green, red}
    typedef logic [PIXEL_W-1:0] pixel_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_bundle_t;

    // low bits of the screen position, feeds the gradient
    typedef struct packed {
        logic [3:0] x;
        logic [3:0] y;
    } pattern_coord_t;

    // configuration register map
    localparam logic REG_SOURCE = 1'b0;
    localparam logic REG_MUTE   = 1'b1;

    // address register plus RAM read register
    localparam int PIPE_DEPTH = 2;

endpackage
